// File: complexPipePkg.sv
/*
 * Complex integer pipe shared definitions
 * Operand, register and tag widths, the operation encoding
 * and the selective flush window test
 */
package complexPipePkg;

    localparam int dataWidth = 32;
    localparam int phyRegNumWidth = 5;
    localparam int tagWidth = 4;

    typedef logic [dataWidth-1:0] DataPath;
    typedef logic [phyRegNumWidth-1:0] PhyRegNum;
    typedef logic [tagWidth-1:0] OpTag;

    // Multiply and divide flavours
    typedef enum logic [1:0] {
        opMul  = 2'd0,  // low word of the product
        opMulH = 2'd1,  // high word, signed operands
        opDiv  = 2'd2,  // unsigned quotient
        opRem  = 2'd3   // unsigned remainder
    } ComplexOpType;

    // Iterative divider sequencing
    typedef enum logic [1:0] {
        idle = 2'd0,
        busy = 2'd1,
        done = 2'd2
    } DivState;

    typedef struct packed {
        ComplexOpType opType;
        PhyRegNum srcRegA;
        PhyRegNum srcRegB;
        PhyRegNum dstReg;
        logic writeReg;
        OpTag tag;
    } ComplexOp;

    // True when the tag sits inside the circular flush window
    function automatic logic isFlushed(
        input logic flushAll,
        input OpTag headTag,
        input OpTag tailTag,
        input OpTag tag
    );
        logic inRange;
        if (headTag <= tailTag) begin
            inRange = (tag >= headTag) && (tag <= tailTag);
        end else begin
            // Window wraps past the top tag
            inRange = (tag >= headTag) || (tag <= tailTag);
        end
        return flushAll || inRange;
    endfunction

endpackage

// File: complexPipeIf.sv
/*
 * Stage-to-stage buses of the complex integer pipe
 * issueIf carries the issued op plus back-end stall and clear,
 * execIf carries the op with its source operands
 */
`timescale 1ns/1ps

interface issueIf import complexPipePkg::*; ();
    logic valid;
    ComplexOp op;
    logic stall;
    logic clear;

    modport producer (
        output valid,
        output op,
        input stall
    );

    modport consumer (
        input valid,
        input op,
        input stall,
        input clear
    );
endinterface

interface execIf import complexPipePkg::*; ();
    logic valid;
    ComplexOp op;
    DataPath operandA;
    DataPath operandB;
    logic cancelDiv;

    modport producer (
        output valid,
        output op,
        output operandA,
        output operandB,
        output cancelDiv
    );

    modport consumer (
        input valid,
        input op,
        input operandA,
        input operandB,
        input cancelDiv
    );
endinterface

// File: physRegFile.sv
/*
 * Physical register file
 * Two read ports, one write port, write-through on reads
 */
`timescale 1ns/1ps

module physRegFile import complexPipePkg::*; #(
    parameter int numPhyRegs = 32
) (
    input logic clk,
    input logic rstN,
    input PhyRegNum rdRegA,
    input PhyRegNum rdRegB,
    output DataPath rdDataA,
    output DataPath rdDataB,
    input logic wrEn,
    input PhyRegNum wrReg,
    input DataPath wrData
);

    DataPath regs [numPhyRegs];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < numPhyRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wrReg] <= wrData;
        end
    end

    // Same-cycle write shows up on both readers
    assign rdDataA = (wrEn && (wrReg == rdRegA)) ? wrData : regs[rdRegA];
    assign rdDataB = (wrEn && (wrReg == rdRegB)) ? wrData : regs[rdRegB];

endmodule

// File: complexIssueQueue.sv
/*
 * Complex integer issue queue
 * In-order FIFO that tags each op, drops flushed entries
 * and issues one op per cycle while the back end is free
 */
`timescale 1ns/1ps

module complexIssueQueue import complexPipePkg::*; #(
    parameter int queueDepth = 8
) (
    input logic clk,
    input logic rstN,
    input logic enqValid,
    input ComplexOp enqOp,
    output logic enqReady,
    output OpTag enqTag,
    input logic flushValid,
    input logic flushAll,
    input OpTag flushHead,
    input OpTag flushTail,
    issueIf.producer issue
);

    localparam int ptrWidth = (queueDepth > 1) ? $clog2(queueDepth) : 1;

    ComplexOp entryOp [queueDepth];
    logic [queueDepth-1:0] entryValid;
    logic [ptrWidth-1:0] headPtr;
    logic [ptrWidth-1:0] tailPtr;
    logic [ptrWidth:0] count;
    OpTag nextTag;
    ComplexOp stampedOp;
    logic empty;
    logic full;
    logic push;
    logic pop;
    logic headFlush;

    function automatic logic [ptrWidth-1:0] nextPtr(input logic [ptrWidth-1:0] ptr);
        return (ptr == ptrWidth'(queueDepth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign empty = (count == '0);
    assign full = (count == (ptrWidth + 1)'(queueDepth));
    assign enqReady = !full;
    assign enqTag = nextTag;
    assign push = enqValid && !full;

    always_comb begin
        stampedOp = enqOp;
        stampedOp.tag = nextTag;
    end

    // Head hit by this cycle's flush never leaves
    assign headFlush = flushValid &&
        isFlushed(flushAll, flushHead, flushTail, entryOp[headPtr].tag);
    assign issue.valid = !empty && entryValid[headPtr] && !headFlush;
    assign issue.op = entryOp[headPtr];

    // Dead entries drain from the head regardless of stall
    assign pop = !empty && (!issue.valid || !issue.stall);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            headPtr <= '0;
            tailPtr <= '0;
            count <= '0;
            nextTag <= '0;
            entryValid <= '0;
        end else begin
            for (int i = 0; i < queueDepth; i++) begin
                if (flushValid && isFlushed(flushAll, flushHead, flushTail, entryOp[i].tag)) begin
                    entryValid[i] <= 1'b0;
                end
            end
            if (push) begin
                entryValid[tailPtr] <= !(flushValid &&
                    isFlushed(flushAll, flushHead, flushTail, nextTag));
                tailPtr <= nextPtr(tailPtr);
                nextTag <= nextTag + 1'b1;
            end
            if (pop) begin
                headPtr <= nextPtr(headPtr);
            end
            count <= count + push - pop;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entryOp[tailPtr] <= stampedOp;
        end
    end

endmodule

// File: registerReadStage.sv
/*
 * Complex integer register-read stage
 * Holds one issued op, reads its sources from the register file
 * and applies selective flush on the way to execution
 */
`timescale 1ns/1ps

module registerReadStage import complexPipePkg::*; (
    input logic clk,
    input logic rstN,
    issueIf.consumer issue,
    output PhyRegNum srcRegA,
    output PhyRegNum srcRegB,
    input DataPath srcDataA,
    input DataPath srcDataB,
    input logic flushValid,
    input logic flushAll,
    input OpTag flushHead,
    input OpTag flushTail,
    execIf.producer exec
);

    ComplexOp pipeOp;
    logic pipeValid;
    logic flushHit;
    logic isDiv;

    // Held op is dropped if recovery hits it while stalled
    always_ff @(posedge clk) begin
        if (!rstN) begin
            pipeValid <= 1'b0;
        end else if (!issue.stall) begin
            pipeValid <= issue.valid && !issue.clear;
        end else if (flushHit || issue.clear) begin
            pipeValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!issue.stall) begin
            pipeOp <= issue.op;
        end
    end

    assign flushHit = flushValid && isFlushed(flushAll, flushHead, flushTail, pipeOp.tag);
    assign isDiv = (pipeOp.opType == opDiv) || (pipeOp.opType == opRem);

    // Register file lookup
    assign srcRegA = pipeOp.srcRegA;
    assign srcRegB = pipeOp.srcRegB;

    assign exec.valid = pipeValid && !issue.stall && !issue.clear && !flushHit;
    assign exec.op = pipeOp;
    assign exec.operandA = srcDataA;
    assign exec.operandB = srcDataB;

    // Divide flushed here gives up its divider slot
    assign exec.cancelDiv = pipeValid && isDiv && flushHit;

endmodule

// File: complexExecStage.sv
/*
 * Complex integer execution stage
 * Single-cycle multiplier and 32-step shift-subtract divider,
 * raises the back-end stall while dividing and drives writeback
 */
`timescale 1ns/1ps

module complexExecStage import complexPipePkg::*; (
    input logic clk,
    input logic rstN,
    execIf.consumer exec,
    input logic flushValid,
    input logic flushAll,
    input OpTag flushHead,
    input OpTag flushTail,
    output logic stall,
    output logic wbValid,
    output PhyRegNum wbReg,
    output DataPath wbData,
    output OpTag wbTag
);

    localparam int countWidth = $clog2(dataWidth);

    ComplexOp curOp;
    DataPath srcA;
    DataPath srcB;
    logic mulValid;
    DivState divState;
    logic [countWidth-1:0] divCount;
    DataPath quotient;
    DataPath remainder;
    logic [dataWidth:0] shiftedRem;
    logic [dataWidth:0] remDiff;
    logic divFits;
    logic [2*dataWidth-1:0] product;
    logic isDivOp;
    logic startDiv;
    logic flushHit;

    assign isDivOp = (exec.op.opType == opDiv) || (exec.op.opType == opRem);
    assign startDiv = exec.valid && isDivOp && !exec.cancelDiv;
    assign flushHit = flushValid && isFlushed(flushAll, flushHead, flushTail, curOp.tag);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            mulValid <= 1'b0;
            divState <= idle;
            divCount <= '0;
        end else begin
            mulValid <= exec.valid && !isDivOp;
            case (divState)
                idle: begin
                    if (startDiv) begin
                        divState <= busy;
                        divCount <= '0;
                    end
                end
                busy: begin
                    divCount <= divCount + 1'b1;
                    if (flushHit) begin
                        divState <= idle;
                    end else if (divCount == countWidth'(dataWidth - 1)) begin
                        divState <= done;
                    end
                end
                default: divState <= idle;
            endcase
        end
    end

    // One quotient bit per busy cycle
    assign shiftedRem = {remainder, quotient[dataWidth-1]};
    assign remDiff = shiftedRem - {1'b0, srcB};
    assign divFits = (shiftedRem >= {1'b0, srcB});

    always_ff @(posedge clk) begin
        if (exec.valid) begin
            curOp <= exec.op;
            srcA <= exec.operandA;
            srcB <= exec.operandB;
        end
        if (startDiv) begin
            quotient <= exec.operandA;
            remainder <= '0;
        end else if (divState == busy) begin
            quotient <= {quotient[dataWidth-2:0], divFits};
            remainder <= divFits ? remDiff[dataWidth-1:0] : shiftedRem[dataWidth-1:0];
        end
    end

    assign product = $signed(srcA) * $signed(srcB);
    assign stall = (divState != idle);

    always_comb begin
        case (curOp.opType)
            opMul: wbData = product[dataWidth-1:0];
            opMulH: wbData = product[2*dataWidth-1:dataWidth];
            opDiv: wbData = quotient;
            default: wbData = remainder;
        endcase
    end

    // Register file is written at the edge that ends this cycle
    assign wbValid = (mulValid || (divState == done)) && curOp.writeReg && !flushHit;
    assign wbReg = curOp.dstReg;
    assign wbTag = curOp.tag;

endmodule

// File: complexPipeTop.sv
/*
 * Complex integer pipe top level
 * Issue queue, register read, execution and register file
 * behind plain enqueue, load, flush and writeback ports
 */
`timescale 1ns/1ps

module complexPipeTop import complexPipePkg::*; #(
    parameter int queueDepth = 8,
    parameter int numPhyRegs = 32
) (
    input logic clk,
    input logic rstN,
    input logic enqValid,
    input ComplexOpType enqOpType,
    input PhyRegNum enqSrcA,
    input PhyRegNum enqSrcB,
    input PhyRegNum enqDst,
    output logic enqReady,
    output OpTag enqTag,
    input logic loadEn,
    input PhyRegNum loadReg,
    input DataPath loadData,
    input logic flushValid,
    input logic flushAll,
    input OpTag flushHead,
    input OpTag flushTail,
    output logic wbValid,
    output PhyRegNum wbReg,
    output DataPath wbData,
    output OpTag wbTag
);

    issueIf issueBus ();
    execIf execBus ();

    ComplexOp enqOp;
    logic execStall;
    PhyRegNum rdRegA;
    PhyRegNum rdRegB;
    DataPath rdDataA;
    DataPath rdDataB;
    logic rfWrEn;
    PhyRegNum rfWrReg;
    DataPath rfWrData;

    // Every complex op has a destination, tag comes from the queue
    assign enqOp = '{opType: enqOpType, srcRegA: enqSrcA, srcRegB: enqSrcB,
                     dstReg: enqDst, writeReg: 1'b1, tag: '0};

    assign issueBus.stall = execStall;
    assign issueBus.clear = flushValid && flushAll;

    // Writeback wins over the load port
    assign rfWrEn = wbValid || loadEn;
    assign rfWrReg = wbValid ? wbReg : loadReg;
    assign rfWrData = wbValid ? wbData : loadData;

    complexIssueQueue #(
        .queueDepth(queueDepth)
    ) issueQueue (
        .clk(clk), .rstN(rstN),
        .enqValid(enqValid), .enqOp(enqOp), .enqReady(enqReady), .enqTag(enqTag),
        .flushValid(flushValid), .flushAll(flushAll),
        .flushHead(flushHead), .flushTail(flushTail),
        .issue(issueBus.producer)
    );

    registerReadStage regRead (
        .clk(clk), .rstN(rstN),
        .issue(issueBus.consumer),
        .srcRegA(rdRegA), .srcRegB(rdRegB), .srcDataA(rdDataA), .srcDataB(rdDataB),
        .flushValid(flushValid), .flushAll(flushAll),
        .flushHead(flushHead), .flushTail(flushTail),
        .exec(execBus.producer)
    );

    physRegFile #(
        .numPhyRegs(numPhyRegs)
    ) regFile (
        .clk(clk), .rstN(rstN),
        .rdRegA(rdRegA), .rdRegB(rdRegB), .rdDataA(rdDataA), .rdDataB(rdDataB),
        .wrEn(rfWrEn), .wrReg(rfWrReg), .wrData(rfWrData)
    );

    complexExecStage execStage (
        .clk(clk), .rstN(rstN),
        .exec(execBus.consumer),
        .flushValid(flushValid), .flushAll(flushAll),
        .flushHead(flushHead), .flushTail(flushTail),
        .stall(execStall),
        .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData), .wbTag(wbTag)
    );

endmodule

// File: tbComplexPipe.sv
/*
 * Testbench for the complex integer pipe
 * Replays the stimulus file and checks every writeback in program order
 * against a register model built from the opcode rules
 */
`timescale 1ns/1ps

module tbComplexPipe;
    import complexPipePkg::*;

    typedef struct {
        logic [3:0] tag;
        ComplexOpType opType;
        logic [4:0] srcA;
        logic [4:0] srcB;
        logic [4:0] dst;
        logic [31:0] fileExp;
    } PendingOp;

    logic clk;
    logic rstN;
    logic enqValid;
    ComplexOpType enqOpType;
    logic [4:0] enqSrcA;
    logic [4:0] enqSrcB;
    logic [4:0] enqDst;
    logic enqReady;
    logic [3:0] enqTag;
    logic loadEn;
    logic [4:0] loadReg;
    logic [31:0] loadData;
    logic flushValid;
    logic flushAll;
    logic [3:0] flushHead;
    logic [3:0] flushTail;
    logic wbValid;
    logic [4:0] wbReg;
    logic [31:0] wbData;
    logic [3:0] wbTag;

    PendingOp pending[$];
    logic [3:0] issuedTags[$];
    logic [31:0] regModel [32];
    logic [3:0] expTag;
    string cmdKind[$];
    string cmdOp[$];
    int cmdA[$];
    int cmdB[$];
    int cmdC[$];
    logic [31:0] cmdD[$];
    int errors;
    int checkedCount;
    int acceptedCount;
    int flushedCount;
    int cycleCount;
    int timeoutLimit;
    bit sawFull;

    complexPipeTop #(.queueDepth(8), .numPhyRegs(32)) i_dut (
        .clk(clk), .rstN(rstN),
        .enqValid(enqValid), .enqOpType(enqOpType), .enqSrcA(enqSrcA),
        .enqSrcB(enqSrcB), .enqDst(enqDst), .enqReady(enqReady), .enqTag(enqTag),
        .loadEn(loadEn), .loadReg(loadReg), .loadData(loadData),
        .flushValid(flushValid), .flushAll(flushAll),
        .flushHead(flushHead), .flushTail(flushTail),
        .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData), .wbTag(wbTag)
    );

    always #4 clk = ~clk;

    // Circular tag window inclusive at both ends
    function automatic bit tagInWindow(logic [3:0] head, logic [3:0] tail, logic [3:0] t);
        if (head <= tail) begin
            return (t >= head) && (t <= tail);
        end
        return (t >= head) || (t <= tail);
    endfunction

    function automatic logic [31:0] expectedResult(ComplexOpType op, logic [31:0] a,
                                                   logic [31:0] b);
        longint sa;
        longint sb;
        longint prod;
        sa = $signed(a);
        sb = $signed(b);
        prod = sa * sb;
        case (op)
            opMul: return a * b;
            opMulH: return prod[63:32];
            opDiv: return (b == 0) ? 32'hffffffff : a / b;
            default: return (b == 0) ? a : a % b;
        endcase
    endfunction

    function automatic ComplexOpType opFromName(string name);
        if (name == "mulh") return opMulH;
        if (name == "div") return opDiv;
        if (name == "rem") return opRem;
        return opMul;
    endfunction

    // Each writeback is compared with the oldest pending op
    always @(negedge clk) begin
        PendingOp p;
        logic [31:0] exp;
        if (rstN && wbValid) begin
            if (pending.size() == 0) begin
                $display("Unexpected writeback with no pending op, tag %h", wbTag);
                errors++;
            end else begin
                p = pending.pop_front();
                exp = expectedResult(p.opType, regModel[p.srcA], regModel[p.srcB]);
                if (wbTag != p.tag) begin
                    $display("ERROR wbTag: expected %h, got %h", p.tag, wbTag);
                    errors++;
                end
                if (wbReg != p.dst) begin
                    $display("ERROR wbReg: expected %h, got %h", p.dst, wbReg);
                    errors++;
                end
                if (wbData != exp) begin
                    $display("ERROR wbData: expected %h, got %h", exp, wbData);
                    errors++;
                end
                if (exp != p.fileExp) begin
                    $display("Stimulus file value %h disagrees with model %h for tag %h",
                             p.fileExp, exp, p.tag);
                    errors++;
                end
                regModel[p.dst] = exp;
                checkedCount++;
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (timeoutLimit > 0 && cycleCount > timeoutLimit) begin
            $display("Timeout after %0d cycles with %0d ops still pending",
                     cycleCount, pending.size());
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    task automatic drainPipe();
        while (pending.size() > 0) begin
            @(posedge clk);
        end
    endtask

    task automatic loadRegister(int idx, logic [31:0] value);
        drainPipe();
        @(posedge clk);
        loadEn <= 1'b1;
        loadReg <= 5'(idx);
        loadData <= value;
        regModel[idx] = value;
        @(posedge clk);
        loadEn <= 1'b0;
    endtask

    task automatic enqueueOp(string name, int a, int b, int d, logic [31:0] fileExp);
        PendingOp p;
        repeat ($urandom % 4) @(posedge clk);
        @(posedge clk);
        enqValid <= 1'b1;
        enqOpType <= opFromName(name);
        enqSrcA <= 5'(a);
        enqSrcB <= 5'(b);
        enqDst <= 5'(d);
        @(negedge clk);
        while (!enqReady) begin
            sawFull = 1'b1;
            @(negedge clk);
        end
        if (enqTag != expTag) begin
            $display("ERROR enqTag: expected %h, got %h", expTag, enqTag);
            errors++;
        end
        p = '{tag: expTag, opType: opFromName(name), srcA: 5'(a), srcB: 5'(b),
              dst: 5'(d), fileExp: fileExp};
        pending.push_back(p);
        issuedTags.push_back(expTag);
        expTag = expTag + 1'b1;
        acceptedCount++;
        @(posedge clk);
        enqValid <= 1'b0;
    endtask

    // Flush everything or only the newest count ops
    task automatic applyFlush(int all, int count);
        logic [3:0] head;
        logic [3:0] tail;
        logic [3:0] divTag;
        bit haveDiv;
        PendingOp kept[$];
        head = '0;
        tail = '0;
        divTag = '0;
        haveDiv = 1'b0;
        if (all != 0) begin
            // Older ops retire first so the flush hits the newest divide in flight
            foreach (pending[i]) begin
                if (pending[i].opType == opDiv || pending[i].opType == opRem) begin
                    divTag = pending[i].tag;
                    haveDiv = 1'b1;
                end
            end
            while (haveDiv && pending.size() > 0 && pending[0].tag != divTag) begin
                @(posedge clk);
            end
        end else begin
            head = issuedTags[issuedTags.size() - count];
            tail = issuedTags[issuedTags.size() - 1];
        end
        @(posedge clk);
        flushValid <= 1'b1;
        flushAll <= (all != 0);
        flushHead <= head;
        flushTail <= tail;
        foreach (pending[i]) begin
            if (all != 0 || tagInWindow(head, tail, pending[i].tag)) begin
                flushedCount++;
            end else begin
                kept.push_back(pending[i]);
            end
        end
        pending = kept;
        @(posedge clk);
        flushValid <= 1'b0;
        flushAll <= 1'b0;
    endtask

    initial begin
        int fd;
        string kind;
        string opName;
        string rest;
        int a;
        int b;
        int c;
        logic [31:0] d;
        clk = 1'b0;
        rstN = 1'b0;
        enqValid = 1'b0;
        enqOpType = opMul;
        enqSrcA = '0;
        enqSrcB = '0;
        enqDst = '0;
        loadEn = 1'b0;
        loadReg = '0;
        loadData = '0;
        flushValid = 1'b0;
        flushAll = 1'b0;
        flushHead = '0;
        flushTail = '0;
        expTag = '0;
        errors = 0;
        checkedCount = 0;
        acceptedCount = 0;
        flushedCount = 0;
        cycleCount = 0;
        timeoutLimit = 0;
        sawFull = 1'b0;
        void'($urandom(32'h13e35ef9));
        for (int i = 0; i < 32; i++) begin
            regModel[i] = '0;
        end
        fd = $fopen("complexPipeStimulus.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file");
            $display("SOME TESTS FAILED");
            $finish;
        end else begin
            while ($fscanf(fd, "%s", kind) == 1) begin
                a = 0;
                b = 0;
                c = 0;
                d = '0;
                opName = "";
                if (kind.getc(0) == 8'h23) begin
                    void'($fgets(rest, fd));
                end else begin
                    if (kind == "E") begin
                        void'($fscanf(fd, "%s %d %d %d %h", opName, a, b, c, d));
                    end else if (kind == "L") begin
                        void'($fscanf(fd, "%d %h", a, d));
                    end else if (kind == "F") begin
                        void'($fscanf(fd, "%d %d", a, b));
                    end else begin
                        void'($fscanf(fd, "%d", a));
                    end
                    cmdKind.push_back(kind);
                    cmdOp.push_back(opName);
                    cmdA.push_back(a);
                    cmdB.push_back(b);
                    cmdC.push_back(c);
                    cmdD.push_back(d);
                end
            end
            $fclose(fd);
            timeoutLimit = 40 * cmdKind.size() + 200;

            repeat (4) @(posedge clk);
            rstN <= 1'b1;
            foreach (cmdKind[i]) begin
                case (cmdKind[i])
                    "L": loadRegister(cmdA[i], cmdD[i]);
                    "E": enqueueOp(cmdOp[i], cmdA[i], cmdB[i], cmdC[i], cmdD[i]);
                    "F": applyFlush(cmdA[i], cmdB[i]);
                    default: repeat (cmdA[i]) @(posedge clk);
                endcase
            end
            drainPipe();
            repeat (10) @(posedge clk);

            if (!sawFull) begin
                $display("enqReady never dropped while the queue was backed up");
                errors++;
            end
            if (checkedCount + flushedCount != acceptedCount) begin
                $display("Accepted %0d ops but saw %0d writebacks and %0d flushed",
                         acceptedCount, checkedCount, flushedCount);
                errors++;
            end
            $display("Errors: %0d, writebacks checked: %0d, flushed: %0d",
                     errors, checkedCount, flushedCount);
            if (errors == 0) begin
                $display("ALL TESTS PASSED");
            end else begin
                $display("SOME TESTS FAILED");
            end
            $finish;
        end
    end

endmodule

// File: complexPipeStimulus.txt
# L reg data | E op srcA srcB dst expected | F all count(newest ops) | W cycles
# numbers decimal, data and expected values hex
L 1 00000007
L 2 00000003
L 3 fffffffe
L 5 80000000
E mul 1 2 10 00000015
E mulh 3 1 11 ffffffff
E mul 3 3 12 00000004
E mulh 5 5 13 40000000
E div 1 2 14 00000002
E rem 1 2 15 00000001
E div 1 4 16 ffffffff
E rem 1 4 17 00000007
E mul 14 15 18 00000002
E div 3 2 19 55555554
E mul 10 2 20 0000003f
E mul 20 20 20 00000f81
E div 20 1 21 00000237
E div 5 2 22 2aaaaaaa
E mul 1 1 23 00000031
E mul 1 1 1 00000031
E mul 2 2 2 00000009
F 0 3
E mul 1 2 24 00000015
E div 1 2 25 00000002
E mul 2 2 26 00000009
F 1 0
E mul 22 1 27 2aaaaaa6
W 5
E div 1 2 28 00000002
E div 3 1 29 24924924
E mul 1 1 30 00000031
E mul 2 2 31 00000009
E mul 1 2 0 00000015
E mul 2 1 6 00000015
E mul 30 2 7 00000093
E mul 31 31 8 00000051
E mul 6 2 9 0000003f
E mul 7 1 24 00000405
E mul 8 2 25 000000f3
E mul 9 9 26 00000f81
E mulh 29 5 27 edb6db6e
W 20

// File: filelist.f
complexPipePkg.sv
complexPipeIf.sv
physRegFile.sv
complexIssueQueue.sv
registerReadStage.sv
complexExecStage.sv
complexPipeTop.sv
tbComplexPipe.sv

// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary -sv -Wno-fatal --top-module tbComplexPipe -f filelist.f -o simComplexPipe

run: compile
	@out="$$(./obj_dir/simComplexPipe)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
